// ==== hdl/python_defines.svh ====
`ifndef PYTHON_DEFINES_SVH
`define PYTHON_DEFINES_SVH

// sensor word geometry.
`define PYTHON_LANES        4           // data lanes per word.
`define PYTHON_BITS         10          // bits per lane and per sync word.

////////////////////////////////////////////////////////////////////////////
// sync channel codes, full 10-bit word
////////////////////////////////////////////////////////////////////////////
`define PYTHON_SYNC_FS      10'h2aa     // frame start.
`define PYTHON_SYNC_LS      10'h0aa     // line start.
`define PYTHON_SYNC_LE      10'h12a     // line end.
`define PYTHON_SYNC_FE      10'h32a     // frame end.
`define PYTHON_SYNC_IMG     10'h035     // image data.
`define PYTHON_SYNC_BLK     10'h015     // black pixels.
`define PYTHON_SYNC_CRC     10'h059     // crc word.
`define PYTHON_SYNC_TR      10'h3a6     // training pattern.

// default image size in pixels.
`define PYTHON_IMG_WIDTH    640
`define PYTHON_IMG_HEIGHT   480

`endif

// ==== hdl/python_pkg.sv ====
`default_nettype none

`include "python_defines.svh"

package python_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // sync word classes
    ////////////////////////////////////////////////////////////////////////////

    // one class per known code, other for anything unknown.
    typedef enum logic [3:0] {
        kind_none   ,   // nothing decoded yet.
        kind_fs     ,   // frame start.
        kind_ls     ,   // line start.
        kind_le     ,   // line end.
        kind_fe     ,   // frame end.
        kind_img    ,   // image word.
        kind_blk    ,   // black word.
        kind_crc    ,   // crc word.
        kind_tr     ,   // training word.
        kind_other      // unknown code.
    } sync_kind_e;

    ////////////////////////////////////////////////////////////////////////////
    // lane word
    ////////////////////////////////////////////////////////////////////////////

    // lane 0 sits in the low bits.
    typedef logic [`PYTHON_LANES-1:0][`PYTHON_BITS-1:0] lanes_t;

endpackage

`default_nettype wire

// ==== hdl/python_sync_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "python_defines.svh"

module python_sync_decode
        (
            input   var logic                   m_axi4s     ,
            input   var logic                   rst_n       ,

            input   var python_pkg::lanes_t     s_data      ,
            input   var logic [9:0]             s_sync      ,
            input   var logic                   s_valid     ,

            output  var python_pkg::sync_kind_e dec_kind    ,
            output  var python_pkg::lanes_t     dec_data    ,
            output  var logic                   dec_stb
        );

    import python_pkg::*;

    ////////////////////////////////////////////////////////////////////////////
    // code table
    ////////////////////////////////////////////////////////////////////////////

    sync_kind_e sync_kind;                          // class of the incoming word.

    always_comb begin
        case (s_sync)
            `PYTHON_SYNC_FS: begin
                sync_kind = kind_fs;                // frame start.
            end
            `PYTHON_SYNC_LS: begin
                sync_kind = kind_ls;                // line start.
            end
            `PYTHON_SYNC_LE: begin
                sync_kind = kind_le;                // line end.
            end
            `PYTHON_SYNC_FE: begin
                sync_kind = kind_fe;                // frame end.
            end
            `PYTHON_SYNC_IMG: begin
                sync_kind = kind_img;               // pixel payload.
            end
            `PYTHON_SYNC_BLK: begin
                sync_kind = kind_blk;               // black reference.
            end
            `PYTHON_SYNC_CRC: begin
                sync_kind = kind_crc;               // crc, not checked.
            end
            `PYTHON_SYNC_TR: begin
                sync_kind = kind_tr;                // training, idle link.
            end
            default: begin
                sync_kind = kind_other;             // unknown code.
            end
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // input register
    ////////////////////////////////////////////////////////////////////////////

    // kind and strobe, one cycle behind s_valid.
    always_ff @(posedge m_axi4s or negedge rst_n) begin
        if (!rst_n) begin
            dec_kind <= kind_none;                  // idle class.
            dec_stb  <= 1'b0;                       // no word.
        end
        else begin
            dec_stb <= s_valid;                     // single-cycle pulse.
            if (s_valid) begin
                dec_kind <= sync_kind;              // hold class until next word.
            end
        end
    end

    // lane payload.
    always_ff @(posedge m_axi4s) begin
        if (s_valid) begin
            dec_data <= s_data;                     // captured with its sync word.
        end
    end

endmodule

`default_nettype wire

// ==== hdl/python_line_gate.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "python_defines.svh"

module python_line_gate
        #(
            parameter int img_width = `PYTHON_IMG_WIDTH
        )
        (
            input   var logic                   m_axi4s     ,
            input   var logic                   rst_n       ,

            input   var python_pkg::sync_kind_e dec_kind    ,
            input   var python_pkg::lanes_t     dec_data    ,
            input   var logic                   dec_stb     ,

            output  var python_pkg::lanes_t     pix_data    ,
            output  var logic                   pix_sof     ,
            output  var logic                   pix_eol     ,
            output  var logic                   pix_eof     ,
            output  var logic                   pix_stb     ,
            output  var logic                   width_error
        );

    import python_pkg::*;

    localparam int line_words = img_width / `PYTHON_LANES;  // words per line.
    localparam int cnt_bits   = $clog2(line_words + 2);     // room for one too many.

    logic                   in_frame;       // between fs and fe.
    logic                   in_line;        // between fs/ls and le/fe.
    logic                   sof_pending;    // next image word opens the frame.
    logic                   hold_valid;     // look-ahead slot full.
    logic                   hold_sof;       // held word is first of frame.
    lanes_t                 hold_data;      // held word payload.
    logic [cnt_bits-1:0]    word_cnt;       // image words in this line.

    logic                   accept_img;     // image word taken into the slot.
    logic                   close_line;     // le or fe inside a line.
    logic                   release_word;   // held word leaves now.
    logic                   end_frame;      // fe inside a frame.

    ////////////////////////////////////////////////////////////////////////////
    // word qualifiers
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        accept_img   = dec_stb && in_line && (dec_kind == kind_img);
        close_line   = dec_stb && in_line && (dec_kind == kind_le || dec_kind == kind_fe);
        release_word = hold_valid && (accept_img || close_line);  // blk, crc, tr skip.
        end_frame    = dec_stb && in_frame && (dec_kind == kind_fe);
    end

    ////////////////////////////////////////////////////////////////////////////
    // frame and line state
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge m_axi4s or negedge rst_n) begin
        if (!rst_n) begin
            in_frame    <= 1'b0;
            in_line     <= 1'b0;
            sof_pending <= 1'b0;
            hold_valid  <= 1'b0;
            hold_sof    <= 1'b0;
            word_cnt    <= '0;
            pix_sof     <= 1'b0;
            pix_eol     <= 1'b0;
            pix_eof     <= 1'b0;
            pix_stb     <= 1'b0;
            width_error <= 1'b0;
        end
        else begin
            pix_stb <= release_word;                    // one pulse per word.
            pix_sof <= release_word && hold_sof;        // first word of frame.
            pix_eol <= release_word && close_line;      // next word ended the line.
            pix_eof <= end_frame;                       // frame closed.

            // sticky until reset.
            if (close_line && word_cnt != cnt_bits'(line_words)) begin
                width_error <= 1'b1;
            end

            if (dec_stb) begin
                case (dec_kind)
                    kind_fs: begin
                        in_frame    <= 1'b1;
                        in_line     <= 1'b1;            // fs opens line 0 too.
                        sof_pending <= 1'b1;
                        hold_valid  <= 1'b0;            // drop any stale word.
                        word_cnt    <= '0;
                    end
                    kind_ls: begin
                        if (in_frame) begin
                            in_line    <= 1'b1;
                            hold_valid <= 1'b0;
                            word_cnt   <= '0;
                        end
                    end
                    kind_img: begin
                        if (in_line) begin
                            hold_valid  <= 1'b1;        // slot refilled.
                            hold_sof    <= sof_pending;
                            sof_pending <= 1'b0;
                            if (word_cnt != '1) begin
                                word_cnt <= word_cnt + 1'b1;  // saturates.
                            end
                        end
                    end
                    kind_le: begin
                        if (in_line) begin
                            in_line    <= 1'b0;
                            hold_valid <= 1'b0;         // released above.
                        end
                    end
                    kind_fe: begin
                        in_frame    <= 1'b0;
                        in_line     <= 1'b0;
                        sof_pending <= 1'b0;
                        hold_valid  <= 1'b0;
                    end
                    default: begin
                        // blk, crc, tr and unknown words leave the state alone.
                    end
                endcase
            end
        end
    end

    // payload path.
    always_ff @(posedge m_axi4s) begin
        if (release_word) begin
            pix_data <= hold_data;      // old word out.
        end
        if (accept_img) begin
            hold_data <= dec_data;      // new word in.
        end
    end

endmodule

`default_nettype wire

// ==== hdl/python_stream_out.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "python_defines.svh"

module python_stream_out
        #(
            parameter int img_height = `PYTHON_IMG_HEIGHT
        )
        (
            input   var logic                   m_axi4s     ,
            input   var logic                   rst_n       ,

            input   var python_pkg::lanes_t     pix_data    ,
            input   var logic                   pix_sof     ,
            input   var logic                   pix_eol     ,
            input   var logic                   pix_eof     ,
            input   var logic                   pix_stb     ,

            output  var python_pkg::lanes_t     tdata       ,
            output  var logic                   tuser       ,
            output  var logic                   tlast       ,
            output  var logic                   tvalid      ,
            output  var logic                   height_error
        );

    localparam int line_bits = $clog2(img_height + 2);  // room for one too many.

    logic [line_bits-1:0]   line_cnt;       // closed lines in this frame.
    logic [line_bits-1:0]   line_base;      // count before this cycle's word.
    logic [line_bits-1:0]   line_next;      // count after this cycle's word.

    ////////////////////////////////////////////////////////////////////////////
    // line counter
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        line_base = (pix_stb && pix_sof) ? '0 : line_cnt;  // new frame restarts.
        line_next = line_base;
        if (pix_stb && pix_eol && line_base != '1) begin
            line_next = line_base + 1'b1;                  // saturates.
        end
    end

    always_ff @(posedge m_axi4s or negedge rst_n) begin
        if (!rst_n) begin
            line_cnt     <= '0;
            height_error <= 1'b0;
        end
        else begin
            if (pix_eof) begin
                // an eol in the same cycle still counts.
                if (line_next != line_bits'(img_height)) begin
                    height_error <= 1'b1;                   // sticky.
                end
                line_cnt <= '0;
            end
            else begin
                line_cnt <= line_next;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // stream register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge m_axi4s or negedge rst_n) begin
        if (!rst_n) begin
            tdata  <= '0;
            tuser  <= 1'b0;
            tlast  <= 1'b0;
            tvalid <= 1'b0;
        end
        else begin
            tvalid <= pix_stb;                  // single-cycle pulse.
            tuser  <= pix_stb && pix_sof;       // only with tvalid.
            tlast  <= pix_stb && pix_eol;
            if (pix_stb) begin
                tdata <= pix_data;              // held between pulses.
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/python_to_axi4s.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "python_defines.svh"

module python_to_axi4s
        #(
            parameter int img_width  = `PYTHON_IMG_WIDTH    ,
            parameter int img_height = `PYTHON_IMG_HEIGHT
        )
        (
            input   var logic                   m_axi4s     ,
            input   var logic                   rst_n       ,

            input   var python_pkg::lanes_t     s_data      ,
            input   var logic [9:0]             s_sync      ,
            input   var logic                   s_valid     ,

            output  var python_pkg::lanes_t     tdata       ,
            output  var logic                   tuser       ,
            output  var logic                   tlast       ,
            output  var logic                   tvalid      ,
            output  var logic                   width_error ,
            output  var logic                   height_error
        );

    import python_pkg::*;

    ////////////////////////////////////////////////////////////////////////////
    // stage wires
    ////////////////////////////////////////////////////////////////////////////

    sync_kind_e dec_kind;       // decode to execute.
    lanes_t     dec_data;
    logic       dec_stb;

    lanes_t     pix_data;       // execute to result.
    logic       pix_sof;
    logic       pix_eol;
    logic       pix_eof;
    logic       pix_stb;

    // decode.
    python_sync_decode
        u_sync_decode
            (
                .m_axi4s        (m_axi4s    ),
                .rst_n          (rst_n      ),
                .s_data         (s_data     ),
                .s_sync         (s_sync     ),
                .s_valid        (s_valid    ),
                .dec_kind       (dec_kind   ),
                .dec_data       (dec_data   ),
                .dec_stb        (dec_stb    )
            );

    // execute.
    python_line_gate
            #(
                .img_width      (img_width  )
            )
        u_line_gate
            (
                .m_axi4s        (m_axi4s    ),
                .rst_n          (rst_n      ),
                .dec_kind       (dec_kind   ),
                .dec_data       (dec_data   ),
                .dec_stb        (dec_stb    ),
                .pix_data       (pix_data   ),
                .pix_sof        (pix_sof    ),
                .pix_eol        (pix_eol    ),
                .pix_eof        (pix_eof    ),
                .pix_stb        (pix_stb    ),
                .width_error    (width_error)
            );

    // result.
    python_stream_out
            #(
                .img_height     (img_height )
            )
        u_stream_out
            (
                .m_axi4s        (m_axi4s    ),
                .rst_n          (rst_n      ),
                .pix_data       (pix_data   ),
                .pix_sof        (pix_sof    ),
                .pix_eol        (pix_eol    ),
                .pix_eof        (pix_eof    ),
                .pix_stb        (pix_stb    ),
                .tdata          (tdata      ),
                .tuser          (tuser      ),
                .tlast          (tlast      ),
                .tvalid         (tvalid     ),
                .height_error   (height_error)
            );

endmodule

`default_nettype wire

// ==== testbench/python_to_axi4s_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "python_defines.svh"

module python_to_axi4s_asserts
        #(
            parameter int img_width = `PYTHON_IMG_WIDTH
        )
        (
            input   var logic               m_axi4s     ,
            input   var logic               rst_n       ,
            input   var python_pkg::lanes_t tdata       ,
            input   var logic               tuser       ,
            input   var logic               tlast       ,
            input   var logic               tvalid      ,
            input   var logic               width_error
        );

    import python_pkg::*;

    localparam int line_words = img_width / `PYTHON_LANES;    // words per line.
    localparam int lane_bits  = `PYTHON_BITS;

    int     fail_cnt = 0;       // failed checks so far.
    int     pos;                // words seen since tuser, modulo line.
    int     cur_pos;            // position of the word now on tdata.
    logic   last_exp;           // word now on tdata closes its line.
    lanes_t prev_word;          // last word seen.
    lanes_t first_word;         // lane i holds i.
    lanes_t next_word;          // one step on from prev_word.

    always_comb begin
        cur_pos  = tuser ? 0 : pos;                         // tuser restarts the count.
        last_exp = (cur_pos == line_words - 1);
        for (int i = 0; i < `PYTHON_LANES; i++) begin
            first_word[i] = lane_bits'(i);
            next_word[i]  = prev_word[i] + lane_bits'(`PYTHON_LANES);
        end
    end

    always_ff @(posedge m_axi4s or negedge rst_n) begin
        if (!rst_n) begin
            pos       <= 0;
            prev_word <= '0;
        end
        else if (tvalid) begin
            pos       <= (cur_pos + 1) % line_words;        // wraps each line.
            prev_word <= tdata;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // stream checks
    ////////////////////////////////////////////////////////////////////////////

    assert property (@(posedge m_axi4s) disable iff (!rst_n)
        !$isunknown(tvalid))
    else begin
        $error("tvalid is unknown");
        fail_cnt++;
    end

    // one word per high cycle, and a line's end leaves a gap.
    assert property (@(posedge m_axi4s) disable iff (!rst_n)
        tvalid && tlast |=> !tvalid)
    else begin
        $error("tvalid held past the end of a line");
        fail_cnt++;
    end

    assert property (@(posedge m_axi4s) disable iff (!rst_n)
        tvalid && tuser |-> tdata == first_word)
    else begin
        $error("mismatch tdata: got 0x%0h expected 0x%0h", $sampled(tdata), first_word);
        fail_cnt++;
    end

    assert property (@(posedge m_axi4s) disable iff (!rst_n)
        tvalid && !tuser |-> tdata == next_word)
    else begin
        $error("mismatch tdata: got 0x%0h expected 0x%0h",
               $sampled(tdata), $sampled(next_word));
        fail_cnt++;
    end

    // short lines are flagged by width_error instead.
    assert property (@(posedge m_axi4s) disable iff (!rst_n)
        tvalid && !width_error |-> tlast == last_exp)
    else begin
        $error("mismatch tlast: got 0x%0h expected 0x%0h",
               $sampled(tlast), $sampled(last_exp));
        fail_cnt++;
    end

    assert property (@(posedge m_axi4s) disable iff (!rst_n)
        tuser || tlast |-> tvalid)
    else begin
        $error("tuser or tlast without tvalid");
        fail_cnt++;
    end

endmodule

bind python_to_axi4s python_to_axi4s_asserts
        #(
            .img_width      (img_width  )
        )
    u_asserts
        (
            .m_axi4s        (m_axi4s    ),
            .rst_n          (rst_n      ),
            .tdata          (tdata      ),
            .tuser          (tuser      ),
            .tlast          (tlast      ),
            .tvalid         (tvalid     ),
            .width_error    (width_error)
        );

`default_nettype wire

// ==== testbench/tb_python_to_axi4s.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "python_defines.svh"

module tb_python_to_axi4s;

    import python_pkg::*;

    localparam int img_width   = 16;
    localparam int img_height  = 3;
    localparam int line_words  = img_width / `PYTHON_LANES;  // 4 words per line.
    localparam int frame_words = line_words * img_height;
    localparam int lane_bits   = `PYTHON_BITS;

    logic       m_axi4s;
    logic       rst_n;
    lanes_t     s_data;
    logic [9:0] s_sync;
    logic       s_valid;
    lanes_t     tdata;
    logic       tuser;
    logic       tlast;
    logic       tvalid;
    logic       width_error;
    logic       height_error;

    int         pix;                // image words sent in this frame.
    int         tvalid_cnt = 0;     // tvalid pulses since time zero.
    int         errors;
    int         test_num;
    int         test_errs;          // error total when the test began.
    int         passed;
    int         failed;

    python_to_axi4s
            #(
                .img_width      (img_width  ),
                .img_height     (img_height )
            )
        UUT
            (
                .m_axi4s        (m_axi4s    ),
                .rst_n          (rst_n      ),
                .s_data         (s_data     ),
                .s_sync         (s_sync     ),
                .s_valid        (s_valid    ),
                .tdata          (tdata      ),
                .tuser          (tuser      ),
                .tlast          (tlast      ),
                .tvalid         (tvalid     ),
                .width_error    (width_error),
                .height_error   (height_error)
            );

    initial begin
        m_axi4s = 1'b0;
        forever #4 m_axi4s = ~m_axi4s;                  // 8 ns period.
    end

    always @(posedge m_axi4s) begin
        if (tvalid) tvalid_cnt <= tvalid_cnt + 1;
    end

    ////////////////////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////////////////////

    function automatic int total_errors();
        return errors + UUT.u_asserts.fail_cnt;
    endfunction

    // word k of a frame, lane i holds 4k + i.
    function automatic lanes_t pixel_word(input int k);
        lanes_t w;
        for (int i = 0; i < `PYTHON_LANES; i++) begin
            w[i] = lane_bits'(k * `PYTHON_LANES + i);
        end
        return w;
    endfunction

    task automatic apply_reset();
        @(posedge m_axi4s);
        #1 rst_n = 1'b0;
        repeat (2) @(posedge m_axi4s);
        #1 rst_n = 1'b1;
    endtask

    task automatic drive_word(input logic [9:0] sync, input lanes_t data);
        @(posedge m_axi4s);
        #1;
        s_sync  = sync;
        s_data  = data;
        s_valid = 1'b1;
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(posedge m_axi4s);
            #1 s_valid = 1'b0;
        end
    endtask

    task automatic random_gap(input int max_gap);
        if (max_gap > 0) idle($urandom % (max_gap + 1));    // 0 .. max_gap cycles.
    endtask

    // blk, crc or training word with junk lanes.
    task automatic send_filler();
        logic [9:0] code;
        case ($urandom % 3)
            0: code = `PYTHON_SYNC_BLK;
            1: code = `PYTHON_SYNC_CRC;
            default: code = `PYTHON_SYNC_TR;
        endcase
        drive_word(code, lanes_t'({$urandom, $urandom}));
    endtask

    task automatic send_frame(input int n_lines, input int last_words, input int max_gap,
                              input bit noisy, input bit stray);
        int n;
        if (stray) begin
            drive_word(`PYTHON_SYNC_IMG, '1);           // no frame open yet.
            drive_word(`PYTHON_SYNC_IMG, '1);
        end
        pix = 0;
        drive_word(`PYTHON_SYNC_FS, '0);
        for (int l = 0; l < n_lines; l++) begin
            n = (l == n_lines - 1) ? last_words : line_words;
            for (int w = 0; w < n; w++) begin
                random_gap(max_gap);
                drive_word(`PYTHON_SYNC_IMG, pixel_word(pix));
                pix++;
                if (noisy && w < n - 1 && $urandom % 2) send_filler();
            end
            random_gap(max_gap);
            drive_word(`PYTHON_SYNC_LE, '0);
            if (l < n_lines - 1) begin
                if (stray) drive_word(`PYTHON_SYNC_IMG, '1);    // between lines.
                drive_word(`PYTHON_SYNC_LS, '0);
            end
        end
        drive_word(`PYTHON_SYNC_FE, '0);
        idle(1);
    endtask

    task automatic wait_words(input int start, input int expected);
        int t;
        t = 0;
        while (tvalid_cnt - start < expected && t < 200) begin
            @(posedge m_axi4s);
            #1 t++;
        end
        if (tvalid_cnt - start < expected) begin
            $display("timeout waiting for words, saw %0d of %0d", tvalid_cnt - start, expected);
            errors++;
        end
        else begin
            idle(8);                                    // room for extra words.
            if (tvalid_cnt - start != expected) begin
                $display("mismatch tvalid count: got 0x%0h expected 0x%0h",
                         tvalid_cnt - start, expected);
                errors++;
            end
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    task automatic end_test(input string name);
        test_num++;
        if (total_errors() > test_errs) begin
            failed++;
            $display("test %0d %s: fail", test_num, name);
        end
        else begin
            passed++;
            $display("test %0d %s: pass", test_num, name);
        end
        test_errs = total_errors();
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // tests
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        int start;
        rst_n    = 1'b0;
        s_valid  = 1'b0;
        s_sync   = '0;
        s_data   = '0;
        errors   = 0;
        test_num = 0;
        passed   = 0;
        failed   = 0;
        void'($urandom(32'h0e546b8a));
        apply_reset();
        test_errs = total_errors();

        start = tvalid_cnt;
        send_frame(img_height, line_words, 0, 1'b0, 1'b0);
        wait_words(start, frame_words);
        check_flag("width_error", width_error, 1'b0);
        check_flag("height_error", height_error, 1'b0);
        end_test("dense frame");

        start = tvalid_cnt;
        send_frame(img_height, line_words, 4, 1'b1, 1'b0);
        wait_words(start, frame_words);
        check_flag("width_error", width_error, 1'b0);
        check_flag("height_error", height_error, 1'b0);
        end_test("gaps and filler words");

        start = tvalid_cnt;
        send_frame(img_height, line_words, 2, 1'b0, 1'b1);
        wait_words(start, frame_words);
        check_flag("width_error", width_error, 1'b0);
        check_flag("height_error", height_error, 1'b0);
        end_test("stray image words");

        start = tvalid_cnt;
        send_frame(img_height, line_words - 1, 0, 1'b0, 1'b0);   // last line short.
        wait_words(start, frame_words - 1);
        check_flag("width_error", width_error, 1'b1);
        check_flag("height_error", height_error, 1'b0);
        start = tvalid_cnt;
        send_frame(img_height, line_words, 0, 1'b0, 1'b0);
        wait_words(start, frame_words);
        check_flag("width_error", width_error, 1'b1);            // still sticky.
        end_test("short line");

        apply_reset();
        start = tvalid_cnt;
        send_frame(img_height - 1, line_words, 0, 1'b0, 1'b0);
        wait_words(start, frame_words - line_words);
        check_flag("height_error", height_error, 1'b1);
        check_flag("width_error", width_error, 1'b0);
        apply_reset();
        check_flag("height_error", height_error, 1'b0);
        check_flag("width_error", width_error, 1'b0);
        check_flag("tvalid", tvalid, 1'b0);
        start = tvalid_cnt;
        send_frame(img_height, line_words, 0, 1'b0, 1'b0);
        wait_words(start, frame_words);
        check_flag("height_error", height_error, 1'b0);
        check_flag("width_error", width_error, 1'b0);
        end_test("short frame then reset");

        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 test_num, passed, failed, total_errors());
        if (failed == 0 && total_errors() == 0) begin
            $display("Everything OK");
        end
        else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+hdl
hdl/python_pkg.sv
hdl/python_sync_decode.sv
hdl/python_line_gate.sv
hdl/python_stream_out.sv
hdl/python_to_axi4s.sv
testbench/python_to_axi4s_asserts.sv
testbench/tb_python_to_axi4s.sv
